// ==== hdl/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// width of data words and bus addresses
`define CPU_XLEN 32

// r15 is the program counter and r14 takes the link
`define CPU_NREGS 16

// op codes at or above this value do nothing
`define CPU_ALU_NOPS 7

// first fetch address
`define CPU_RESET_PC 32'h0000_0000

`endif

// ==== hdl/isa_pkg.sv ====
`default_nettype none
`include "cpu_defs.svh"

package isa_pkg;

   typedef logic [`CPU_XLEN-1:0] word_t;
   typedef logic [$clog2(`CPU_NREGS)-1:0] reg_idx_t;
   typedef logic [3:0] flags_t;   // z c s v from msb down

   localparam int unsigned flag_z = 3;
   localparam int unsigned flag_c = 2;
   localparam int unsigned flag_s = 1;
   localparam int unsigned flag_v = 0;

   typedef enum logic [3:0] {
      cond_al = 4'h0,
      cond_eq = 4'h1,
      cond_ne = 4'h2,
      cond_cs = 4'h3,
      cond_cc = 4'h4,
      cond_mi = 4'h5,
      cond_pl = 4'h6,
      cond_vs = 4'h7,
      cond_vc = 4'h8,
      cond_hi = 4'h9,
      cond_ls = 4'ha,
      cond_ge = 4'hb,
      cond_lt = 4'hc,
      cond_gt = 4'hd,
      cond_le = 4'he,
      cond_uc = 4'hf    // never skipped
   } cond_e;

   // bit 26 selects immediate offset, bit 25 selects load
   typedef enum logic [2:0] {
      alu_rr = 3'd0,
      alu_ri = 3'd1,
      call   = 3'd2,
      halt   = 3'd3,
      st_r   = 3'd4,
      ld_r   = 3'd5,
      st_i   = 3'd6,
      ld_i   = 3'd7
   } iclass_e;

   typedef enum logic [3:0] {
      op_add = 4'd0,
      op_sub = 4'd1,
      op_and = 4'd2,
      op_or  = 4'd3,
      op_xor = 4'd4,
      op_mov = 4'd5,
      op_cmp = 4'd6
   } alu_op_e;

   typedef enum logic [1:0] {
      fetch = 2'd0,
      exec  = 2'd1,
      mem   = 2'd2,
      wback = 2'd3
   } phase_e;

   // fixed instruction layout, immediates are taken from the raw word
   typedef struct packed {
      cond_e      cond;   // 31..28
      iclass_e    cls;    // 27..25
      logic       sf;     // set flags or indexed call
      reg_idx_t   rd;     // 23..20
      reg_idx_t   ra;     // 19..16
      alu_op_e    op;     // 15..12
      reg_idx_t   rb;     // 11..8
      logic [7:0] lo;
   } instr_t;

endpackage

`default_nettype wire

// ==== hdl/bus_pkg.sv ====
`default_nettype none
`include "cpu_defs.svh"

package bus_pkg;

   // wishbone classic master to slave
   typedef struct packed {
      logic                 cyc;
      logic                 stb;
      logic                 we;
      logic [`CPU_XLEN-1:0] adr;
      logic [`CPU_XLEN-1:0] dat;
   } wb_req_t;

   // slave to master
   typedef struct packed {
      logic                 ack;
      logic [`CPU_XLEN-1:0] dat;
   } wb_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/phase_sched.sv ====
`timescale 1ns/1ps
`default_nettype none

module phase_sched
(
   input  wire             clk,
   input  wire             rst_i,
   input  wire             done_i,
   input  wire             mem_wait_i,
   input  wire             halt_i,
   output isa_pkg::phase_e phase_o,
   output logic            start_o
);

   isa_pkg::phase_e phase_q;
   isa_pkg::phase_e phase_d;
   logic            boot_q;   // first fetch after reset

   // the bus request is registered on the edge that enters the phase,
   // so the start pulse comes with the transition
   always_comb
   begin
      phase_d = phase_q;
      start_o = boot_q;
      case (phase_q)
         isa_pkg::fetch:
         begin
            if (done_i)
               phase_d = isa_pkg::exec;
         end
         isa_pkg::exec:
         begin
            phase_d = isa_pkg::mem;
            if (mem_wait_i)
               start_o = 1'b1;   // load or store that passed its condition
         end
         isa_pkg::mem:
         begin
            if (!mem_wait_i || done_i)
               phase_d = isa_pkg::wback;
         end
         default:
         begin
            if (!halt_i)
            begin
               phase_d = isa_pkg::fetch;
               start_o = 1'b1;
            end
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst_i)
      begin
         phase_q <= isa_pkg::fetch;
         boot_q  <= 1'b1;
      end
      else
      begin
         phase_q <= phase_d;   // stays in wback once halted
         boot_q  <= 1'b0;
      end
   end

   assign phase_o = phase_q;

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module reg_file
(
   input  wire                    clk,
   input  wire                    rst_i,
   input  wire isa_pkg::reg_idx_t ra_i,
   input  wire isa_pkg::reg_idx_t rb_i,
   input  wire isa_pkg::reg_idx_t rd_i,
   input  wire isa_pkg::reg_idx_t dbg_sel_i,
   input  wire                    inc_pc_i,
   input  wire                    link_i,
   input  wire                    wb_en_i,
   input  wire isa_pkg::reg_idx_t wb_idx_i,
   input  wire isa_pkg::word_t    wb_data_i,
   output isa_pkg::word_t         da_o,
   output isa_pkg::word_t         db_o,
   output isa_pkg::word_t         dd_o,
   output isa_pkg::word_t         dbg_data_o,
   output isa_pkg::word_t         pc_o
);

   localparam isa_pkg::reg_idx_t pc_idx   = isa_pkg::reg_idx_t'(`CPU_NREGS - 1);
   localparam isa_pkg::reg_idx_t link_idx = isa_pkg::reg_idx_t'(`CPU_NREGS - 2);

   isa_pkg::word_t gpr_q [`CPU_NREGS-1];   // r0 to r14
   isa_pkg::word_t pc_q;

   always_ff @(posedge clk)
   begin
      if (rst_i)
         pc_q <= `CPU_RESET_PC;
      else if (wb_en_i && wb_idx_i == pc_idx)
         pc_q <= wb_data_i;        // branch
      else if (inc_pc_i)
         pc_q <= pc_q + 1;         // word addressed
   end

   // a writeback to r14 wins over the link
   always_ff @(posedge clk)
   begin
      if (link_i)
         gpr_q[link_idx] <= pc_q + 1;
      if (wb_en_i && wb_idx_i != pc_idx)
         gpr_q[wb_idx_i] <= wb_data_i;
   end

   assign da_o       = (ra_i == pc_idx) ? pc_q : gpr_q[ra_i];
   assign db_o       = (rb_i == pc_idx) ? pc_q : gpr_q[rb_i];
   assign dd_o       = (rd_i == pc_idx) ? pc_q : gpr_q[rd_i];
   assign dbg_data_o = (dbg_sel_i == pc_idx) ? pc_q : gpr_q[dbg_sel_i];
   assign pc_o       = pc_q;

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module alu
(
   input  wire isa_pkg::alu_op_e op_i,
   input  wire isa_pkg::word_t   a_i,
   input  wire isa_pkg::word_t   b_i,
   input  wire isa_pkg::flags_t  flags_i,
   output isa_pkg::word_t        res_o,
   output isa_pkg::flags_t       flags_o,
   output logic                  wb_en_o
);

   localparam int msb = `CPU_XLEN - 1;

   logic [`CPU_XLEN:0] sum;    // carry out on top
   logic [`CPU_XLEN:0] diff;   // top bit set on borrow
   logic               c;
   logic               v;

   always_comb
   begin
      sum  = {1'b0, a_i} + {1'b0, b_i};
      diff = {1'b0, a_i} - {1'b0, b_i};
      c    = flags_i[isa_pkg::flag_c];
      v    = flags_i[isa_pkg::flag_v];
      case (op_i)
         isa_pkg::op_add:
         begin
            res_o = sum[msb:0];
            c     = sum[`CPU_XLEN];
            v     = (a_i[msb] == b_i[msb]) && (sum[msb] != a_i[msb]);
         end
         isa_pkg::op_sub,
         isa_pkg::op_cmp:
         begin
            res_o = diff[msb:0];
            c     = !diff[`CPU_XLEN];   // carry means no borrow
            v     = (a_i[msb] != b_i[msb]) && (diff[msb] != a_i[msb]);
         end
         isa_pkg::op_and: res_o = a_i & b_i;
         isa_pkg::op_or:  res_o = a_i | b_i;
         isa_pkg::op_xor: res_o = a_i ^ b_i;
         isa_pkg::op_mov: res_o = b_i;
         default:         res_o = a_i;
      endcase

      flags_o                 = flags_i;
      flags_o[isa_pkg::flag_z] = (res_o == '0);
      flags_o[isa_pkg::flag_c] = c;
      flags_o[isa_pkg::flag_s] = res_o[msb];
      flags_o[isa_pkg::flag_v] = v;
   end

   // cmp only sets flags
   assign wb_en_o = (op_i != isa_pkg::op_cmp) && (int'(op_i) < `CPU_ALU_NOPS);

endmodule

`default_nettype wire

// ==== hdl/wb_bus_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_bus_ctrl
(
   input  wire                   clk,
   input  wire                   rst_i,
   input  wire                   start_i,
   input  wire                   we_i,
   input  wire isa_pkg::word_t   adr_i,
   input  wire isa_pkg::word_t   wdata_i,
   output bus_pkg::wb_req_t      wb_o,
   input  wire bus_pkg::wb_rsp_t wb_i,
   output logic                  done_o,
   output isa_pkg::word_t        rdata_o
);

   logic           cyc_q;
   logic           we_q;
   logic           done_q;
   isa_pkg::word_t adr_q;
   isa_pkg::word_t dat_q;
   isa_pkg::word_t rdata_q;

   always_ff @(posedge clk)
   begin
      if (rst_i)
      begin
         cyc_q  <= 1'b0;
         we_q   <= 1'b0;
         done_q <= 1'b0;
      end
      else
      begin
         done_q <= 1'b0;
         if (cyc_q)
         begin
            if (wb_i.ack)
            begin
               cyc_q  <= 1'b0;   // one transfer per request
               we_q   <= 1'b0;
               done_q <= 1'b1;
            end
         end
         else if (start_i)
         begin
            cyc_q <= 1'b1;
            we_q  <= we_i;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (!cyc_q && start_i)
      begin
         adr_q <= adr_i;   // held until ack
         dat_q <= wdata_i;
      end
      if (cyc_q && wb_i.ack && !we_q)
         rdata_q <= wb_i.dat;
   end

   always_comb
   begin
      wb_o.cyc = cyc_q;
      wb_o.stb = cyc_q;
      wb_o.we  = we_q;
      wb_o.adr = adr_q;
      wb_o.dat = dat_q;
   end

   assign done_o  = done_q;
   assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== hdl/cpu_sys.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defs.svh"

module cpu_sys
(
   input  wire                    clk,
   input  wire                    rst_i,
   output bus_pkg::wb_req_t       wb_o,
   input  wire bus_pkg::wb_rsp_t  wb_i,
   input  wire isa_pkg::reg_idx_t dbg_sel_i,
   output isa_pkg::word_t         dbg_data_o,
   output logic                   halted_o
);

   localparam isa_pkg::reg_idx_t pc_idx = isa_pkg::reg_idx_t'(`CPU_NREGS - 1);

   isa_pkg::phase_e   phase;
   logic              ph_fetch;
   logic              ph_exec;
   logic              ph_wback;
   logic              start;
   logic              done;
   isa_pkg::word_t    rdata;
   isa_pkg::word_t    bus_adr;

   isa_pkg::instr_t   ir_q;
   isa_pkg::word_t    ir_raw;
   isa_pkg::flags_t   flags_q;
   logic              halted_q;
   logic              fz;
   logic              fc;
   logic              fs;
   logic              fv;
   logic              cond_ok;

   logic              is_alu;
   logic              is_call;
   logic              is_ld;
   logic              is_st;
   logic              mem_imm;
   logic              mem_wait;
   logic              halt_req;

   isa_pkg::word_t    da;
   isa_pkg::word_t    db;
   isa_pkg::word_t    dd;
   isa_pkg::word_t    pc;
   isa_pkg::word_t    imm12;
   isa_pkg::word_t    off16;
   isa_pkg::word_t    off20;
   isa_pkg::word_t    tgt_abs;
   isa_pkg::word_t    call_tgt;
   isa_pkg::word_t    mem_adr;
   isa_pkg::word_t    alu_b;
   isa_pkg::word_t    alu_res;
   isa_pkg::flags_t   alu_flags;
   logic              alu_wb_en;

   isa_pkg::reg_idx_t wb_idx;
   isa_pkg::word_t    wb_data;
   logic              wb_en;
   logic              flag_en;

   assign ph_fetch = (phase == isa_pkg::fetch);
   assign ph_exec  = (phase == isa_pkg::exec);
   assign ph_wback = (phase == isa_pkg::wback);

   always_ff @(posedge clk)
   begin
      if (ph_fetch && done)
         ir_q <= isa_pkg::instr_t'(rdata);
   end

   assign ir_raw = ir_q;

   always_ff @(posedge clk)
   begin
      if (rst_i)
      begin
         flags_q  <= '0;
         halted_q <= 1'b0;
      end
      else
      begin
         if (ph_wback && cond_ok && flag_en)
            flags_q <= alu_flags;
         if (ph_wback && halt_req)
            halted_q <= 1'b1;
      end
   end

   assign fz = flags_q[isa_pkg::flag_z];
   assign fc = flags_q[isa_pkg::flag_c];
   assign fs = flags_q[isa_pkg::flag_s];
   assign fv = flags_q[isa_pkg::flag_v];

   always_comb
   begin
      case (ir_q.cond)
         isa_pkg::cond_al: cond_ok = 1'b1;
         isa_pkg::cond_eq: cond_ok = fz;
         isa_pkg::cond_ne: cond_ok = !fz;
         isa_pkg::cond_cs: cond_ok = fc;
         isa_pkg::cond_cc: cond_ok = !fc;
         isa_pkg::cond_mi: cond_ok = fs;
         isa_pkg::cond_pl: cond_ok = !fs;
         isa_pkg::cond_vs: cond_ok = fv;
         isa_pkg::cond_vc: cond_ok = !fv;
         isa_pkg::cond_hi: cond_ok = fc && !fz;          // unsigned higher
         isa_pkg::cond_ls: cond_ok = !fc || fz;
         isa_pkg::cond_ge: cond_ok = (fs == fv);         // signed compares
         isa_pkg::cond_lt: cond_ok = (fs != fv);
         isa_pkg::cond_gt: cond_ok = !fz && (fs == fv);
         isa_pkg::cond_le: cond_ok = fz || (fs != fv);
         default:          cond_ok = 1'b1;
      endcase
   end

   assign is_alu   = (ir_q.cls == isa_pkg::alu_rr) || (ir_q.cls == isa_pkg::alu_ri);
   assign is_call  = (ir_q.cls == isa_pkg::call);
   assign is_ld    = (ir_q.cls == isa_pkg::ld_r) || (ir_q.cls == isa_pkg::ld_i);
   assign is_st    = (ir_q.cls == isa_pkg::st_r) || (ir_q.cls == isa_pkg::st_i);
   assign mem_imm  = (ir_q.cls == isa_pkg::st_i) || (ir_q.cls == isa_pkg::ld_i);
   assign mem_wait = (is_ld || is_st) && cond_ok;
   assign halt_req = (ir_q.cls == isa_pkg::halt) && cond_ok;

   // sign extended immediates
   assign imm12   = {{(`CPU_XLEN-12){ir_raw[11]}}, ir_raw[11:0]};
   assign off16   = {{(`CPU_XLEN-16){ir_raw[15]}}, ir_raw[15:0]};
   assign off20   = {{(`CPU_XLEN-20){ir_raw[19]}}, ir_raw[19:0]};
   assign tgt_abs = {{(`CPU_XLEN-24){1'b0}}, ir_raw[23:0]};

   assign call_tgt = ir_q.sf ? dd + off20 : tgt_abs;   // indexed from rd
   assign mem_adr  = da + (mem_imm ? off16 : db);
   assign alu_b    = (ir_q.cls == isa_pkg::alu_ri) ? imm12 : db;

   assign flag_en = is_alu && (ir_q.sf || ir_q.op == isa_pkg::op_cmp);
   assign wb_en   = ph_wback && cond_ok && ((is_alu && alu_wb_en) || is_call || is_ld);
   assign wb_idx  = is_call ? pc_idx : ir_q.rd;

   always_comb
   begin
      if (is_call)
         wb_data = call_tgt;
      else if (is_ld)
         wb_data = rdata;   // held by the bus controller since mem
      else
         wb_data = alu_res;
   end

   // the request is taken on the edge that leaves exec or wback,
   // where a branch is written to r15 at the same edge
   always_comb
   begin
      case (phase)
         isa_pkg::exec:  bus_adr = mem_adr;
         isa_pkg::wback: bus_adr = (wb_en && wb_idx == pc_idx) ? wb_data : pc;
         default:        bus_adr = pc;
      endcase
   end

   assign halted_o = halted_q;

   phase_sched phase_sched_inst
   (
      .clk        (clk),
      .rst_i      (rst_i),
      .done_i     (done),
      .mem_wait_i (mem_wait),
      .halt_i     (halt_req),
      .phase_o    (phase),
      .start_o    (start)
   );

   reg_file reg_file_inst
   (
      .clk        (clk),
      .rst_i      (rst_i),
      .ra_i       (ir_q.ra),
      .rb_i       (ir_q.rb),
      .rd_i       (ir_q.rd),
      .dbg_sel_i  (dbg_sel_i),
      .inc_pc_i   (ph_exec),
      .link_i     (ph_exec && is_call && cond_ok),
      .wb_en_i    (wb_en),
      .wb_idx_i   (wb_idx),
      .wb_data_i  (wb_data),
      .da_o       (da),
      .db_o       (db),
      .dd_o       (dd),
      .dbg_data_o (dbg_data_o),
      .pc_o       (pc)
   );

   alu alu_inst
   (
      .op_i    (ir_q.op),
      .a_i     (da),
      .b_i     (alu_b),
      .flags_i (flags_q),
      .res_o   (alu_res),
      .flags_o (alu_flags),
      .wb_en_o (alu_wb_en)
   );

   wb_bus_ctrl wb_bus_ctrl_inst
   (
      .clk     (clk),
      .rst_i   (rst_i),
      .start_i (start),
      .we_i    (ph_exec && is_st),
      .adr_i   (bus_adr),
      .wdata_i (dd),       // store data comes from rd
      .wb_o    (wb_o),
      .wb_i    (wb_i),
      .done_o  (done),
      .rdata_o (rdata)
   );

endmodule

`default_nettype wire

// ==== test/cpu_sys_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_sys_checker
(
   input wire                   clk,
   input wire                   rst_i,
   input wire bus_pkg::wb_req_t wb_req_i,
   input wire bus_pkg::wb_rsp_t wb_rsp_i,
   input wire                   halted_i
);

   stb_needs_cyc: assert property (@(posedge clk) disable iff (rst_i)
      wb_req_i.stb |-> wb_req_i.cyc)
      else $error("wishbone stb raised without cyc");

   // request held unchanged until the slave acks
   req_held: assert property (@(posedge clk) disable iff (rst_i)
      (wb_req_i.cyc && !wb_rsp_i.ack) |=> (wb_req_i.cyc && $stable(wb_req_i)))
      else $error("wishbone request changed before ack");

   quiet_after_halt: assert property (@(posedge clk) disable iff (rst_i)
      halted_i |-> !wb_req_i.cyc)
      else $error("bus cycle seen after halt");

endmodule

`default_nettype wire

// ==== test/cpu_sys_mon.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_sys_mon
(
   input  wire                   clk,
   input  wire                   rst_i,
   input  wire bus_pkg::wb_req_t wb_req_i,
   input  wire bus_pkg::wb_rsp_t wb_rsp_i,
   input  wire                   halted_i,
   input  wire isa_pkg::word_t   dbg_data_i,
   input  wire [31:0]            cases_i [0:511],
   output isa_pkg::reg_idx_t     dbg_sel_o,
   output logic                  done_o,
   output int                    store_err_o,
   output int                    reg_err_o
);

   int             st_idx;
   int             st_cnt;
   int             reg_cnt;
   isa_pkg::word_t exp_val;

   initial
   begin
      st_idx      = 0;
      store_err_o = 0;
      reg_err_o   = 0;
      done_o      = 1'b0;
      dbg_sel_o   = '0;
   end

   // every acked write must match the next entry of the store list
   always @(posedge clk)
   begin
      if (!rst_i && wb_req_i.cyc && wb_req_i.stb && wb_req_i.we && wb_rsp_i.ack)
      begin
         st_cnt = int'(cases_i['h100]);
         if (st_idx >= st_cnt)
         begin
            $display("unexpected store to %08h after the expected list ran out",
                     wb_req_i.adr);
            store_err_o = store_err_o + 1;
         end
         else
         begin
            if (wb_req_i.adr !== cases_i['h101 + 2 * st_idx])
            begin
               $display("ERR wb_o.adr store %0d expected %08h got %08h", st_idx,
                        cases_i['h101 + 2 * st_idx], wb_req_i.adr);
               store_err_o = store_err_o + 1;
            end
            if (wb_req_i.dat !== cases_i['h102 + 2 * st_idx])
            begin
               $display("ERR wb_o.dat store %0d expected %08h got %08h", st_idx,
                        cases_i['h102 + 2 * st_idx], wb_req_i.dat);
               store_err_o = store_err_o + 1;
            end
         end
         st_idx = st_idx + 1;
      end
   end

   // final register values through the debug port
   initial
   begin
      wait (halted_i === 1'b1);
      repeat (2) @(posedge clk);
      reg_cnt = int'(cases_i['h180]);
      for (int i = 0; i < reg_cnt; i++)
      begin
         @(negedge clk);
         dbg_sel_o = isa_pkg::reg_idx_t'(cases_i['h181 + 2 * i]);
         exp_val   = cases_i['h182 + 2 * i];
         @(posedge clk);
         if (dbg_data_i !== exp_val)
         begin
            $display("ERR dbg_data_o r%0d expected %08h got %08h", dbg_sel_o,
                     exp_val, dbg_data_i);
            reg_err_o = reg_err_o + 1;
         end
      end
      if (st_idx < int'(cases_i['h100]))
      begin
         $display("only %0d of %0d expected stores were seen", st_idx, cases_i['h100]);
         store_err_o = store_err_o + 1;
      end
      done_o = 1'b1;
   end

endmodule

`default_nettype wire

// ==== test/cpu_sys_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_sys_tb;

   // word offsets in the cases file
   // store list at 'h100 and register list at 'h180 each start with a count
   localparam int size_word  = 'h1f0;   // program word count

   logic                 clk;
   logic                 rst_i;
   bus_pkg::wb_req_t     wb_req;
   bus_pkg::wb_rsp_t     wb_rsp;
   isa_pkg::reg_idx_t    dbg_sel;
   isa_pkg::word_t       dbg_data;
   logic                 halted;

   logic [31:0]          cases [0:511];
   logic [31:0]          mem [0:255];
   integer               seed;
   int                   delay;
   logic                 busy;
   int                   limit;
   logic                 mon_done;
   int                   store_err;
   int                   reg_err;

   always #5 clk = ~clk;

   initial
   begin
      clk    = 1'b0;
      rst_i  = 1'b1;
      wb_rsp = '0;
      seed   = 95;
      busy   = 1'b0;
      delay  = 0;
      for (int i = 0; i < 512; i++)
         cases[i] = 32'h5a5a_0000 | i;   // unused words stay recognizable
      $readmemh("test/cpu_sys_cases.txt", cases);
      for (int i = 0; i < 256; i++)
         mem[i] = cases[i];
      repeat (4) @(negedge clk);
      rst_i = 1'b0;
   end

   // memory slave acks after 0 to 3 extra cycles
   always @(negedge clk)
   begin
      if (rst_i)
      begin
         wb_rsp = '0;
         busy   = 1'b0;
      end
      else if (wb_rsp.ack)
         wb_rsp.ack = 1'b0;   // one cycle only
      else if (wb_req.cyc && wb_req.stb)
      begin
         if (!busy)
         begin
            busy  = 1'b1;
            delay = $unsigned($random(seed)) % 4;
         end
         if (delay == 0)
         begin
            busy       = 1'b0;
            wb_rsp.ack = 1'b1;
            if (wb_req.we)
               mem[wb_req.adr[7:0]] = wb_req.dat;
            else
               wb_rsp.dat = mem[wb_req.adr[7:0]];
         end
         else
            delay = delay - 1;
      end
   end

   cpu_sys cpu_sys_inst
   (
      .clk        (clk),
      .rst_i      (rst_i),
      .wb_o       (wb_req),
      .wb_i       (wb_rsp),
      .dbg_sel_i  (dbg_sel),
      .dbg_data_o (dbg_data),
      .halted_o   (halted)
   );

   cpu_sys_mon cpu_sys_mon_inst
   (
      .clk         (clk),
      .rst_i       (rst_i),
      .wb_req_i    (wb_req),
      .wb_rsp_i    (wb_rsp),
      .halted_i    (halted),
      .dbg_data_i  (dbg_data),
      .cases_i     (cases),
      .dbg_sel_o   (dbg_sel),
      .done_o      (mon_done),
      .store_err_o (store_err),
      .reg_err_o   (reg_err)
   );

   // each instruction needs well under 40 cycles even with slow acks
   initial
   begin
      #1;
      limit = int'(cases[size_word]) * 40;
      repeat (limit) @(posedge clk);
      $display("watchdog expired after %0d cycles without finishing the checks", limit);
      $display("RESULT: FAIL");
      $finish;
   end

   initial
   begin
      wait (mon_done === 1'b1);
      @(posedge clk);
      $display("errors: %0d store, %0d register, %0d total",
               store_err, reg_err, store_err + reg_err);
      if (store_err + reg_err == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

bind cpu_sys cpu_sys_checker cpu_sys_checker_inst
(
   .clk      (clk),
   .rst_i    (rst_i),
   .wb_req_i (wb_o),
   .wb_rsp_i (wb_i),
   .halted_i (halted_o)
);

`default_nettype wire

// ==== test/cpu_sys_cases.txt ====
// @000 program and data image, one 32-bit hex word per entry
// @100 store count then adr dat pairs, @180 register count then index value pairs
@000
020050C0 02105123 022050F0 00310200 // mov r0 r1 r2, add r3
0C300000 00411200 0C400001 025120F0 // st, sub, st, and
00613200 02714FFF 0C500002 0C600003 // or, xor, st, st
0C700004 02805000 02905000 00016200 // st, clear r8 r9, cmp r1 r2
02883001 12883002 22883004 32883008 // conditional or, codes 0 to 3
42883010 52883020 62883040 72883080 // codes 4 to 7
82883100 92883200 A2883400 B2993001 // codes 8 to 11
C2993002 D2993004 E2993008 F2993010 // codes 12 to 15
0C800005 0C900006 00026100 C2A05011 // st r8 r9, cmp r2 r1, lt mov
B2A05022 1CA0000F 5CA00007 02B05080 // ge mov, skipped st, mi st, mov r11
0ECB0000 02D05008 0A3B0D00 08C00D00 // ld imm, mov r13, ld reg, st reg
0C300009 04000040 05BFFFC8 06000000 // st, call abs, call indexed, halt
0C30000E                            // never fetched
@040
0CE0000A 00F05E00                   // store link, return
@048
0CE0000B 00F05E00
@080
DEADBEEF
@088
0BADF00D
@100
0000000C
000000C0 00000213 000000C1 00000033 000000C2 00000020 000000C3 000001F3
000000C4 FFFFFEDC 000000C5 0000034D 000000C6 00000015 000000C7 00000011
000000C8 DEADBEEF 000000C9 0BADF00D 000000CA 0000002E 000000CB 0000002F
@180
00000007
00000003 0BADF00D 00000008 0000034D 00000009 00000015 0000000A 00000011
0000000C DEADBEEF 0000000E 0000002F 0000000F 00000030
@1F0
00000035

// ==== cpu_sys.f ====
+incdir+hdl
hdl/isa_pkg.sv
hdl/bus_pkg.sv
hdl/phase_sched.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/wb_bus_ctrl.sv
hdl/cpu_sys.sv
test/cpu_sys_checker.sv
test/cpu_sys_mon.sv
test/cpu_sys_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" \
   && verilator --binary --timing --assert -f cpu_sys.f --top-module cpu_sys_tb \
      -o sim_cpu_sys \
   && ./obj_dir/sim_cpu_sys | tee /dev/stderr | grep -qx "RESULT: PASS" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
